// File: life_engine.f
+incdir+include
src/life_pkg.sv
src/life_if.sv
src/cell_ram.sv
src/pass_control.sv
src/row_window.sv
src/life_row.sv
src/life_engine_top.sv
tb/tb_life_engine.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Life engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_life_engine

verilator --binary --timing -j 0 -f life_engine.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

# The log decides the result
if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0

// File: include/life_tb_cases.svh
/*
 Stimulus table for the Life engine testbench
 Start boards, random fill flags and pass counts
*/
`ifndef LIFE_TB_CASES_SVH
`define LIFE_TB_CASES_SVH

// Each case has a name, a start board, a random fill flag and a pass count
// Row 0 sits in the top WIDTH bits of a board
// Bit n of a row is column n
localparam int NUM_CASES = 6;

string case_name [NUM_CASES] = '{
	"readback", "block", "blinker", "glider_wrap", "random_a", "random_b"
};

logic [WIDTH*DEPTH-1:0] case_board [NUM_CASES] = '{
	128'h0000_0000_0000_0000_0000_0000_0000_0000,	// Filled at random
	128'h0000_0000_0000_0180_0180_0000_0000_0000,	// 2x2 block still life
	128'h0000_0000_0000_0000_01C0_0000_0000_0000,	// Period 2 blinker
	128'h8003_0000_0000_0000_0000_0000_0001_0002,	// Glider over both edges
	128'h0000_0000_0000_0000_0000_0000_0000_0000,
	128'h0000_0000_0000_0000_0000_0000_0000_0000
};

bit case_rand [NUM_CASES] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
int case_gens [NUM_CASES] = '{0, 1, 2, 4, 3, 3};	// 0 is init and readback only

`endif

// File: tb/tb_life_engine.sv
/*
 Testbench for the streaming Life engine on a 16 by 8 torus
 Table driven cases checked against a software model of the rule
*/
`timescale 1ns/1ps
module tb_life_engine
	import life_pkg::*;
();

	localparam int WIDTH      = 16;
	localparam int DEPTH      = 8;
	localparam int AW         = $clog2(DEPTH);
	localparam int RST_CYCLES = 16;
	localparam int SEED       = 32'h9918_3315;

	`include "life_tb_cases.svh"

	logic             clk;
	logic             arst_n;
	logic             init;
	logic [AW-1:0]    init_row;
	logic [WIDTH-1:0] init_data;
	logic             start;
	logic             ld;
	logic [AW-1:0]    ld_row;
	logic [WIDTH-1:0] dout;
	logic             dout_valid;
	logic             busy;
	logic             done;

	logic [WIDTH-1:0] model_board [DEPTH];	// Expected current generation
	int errors;
	int checks;
	int cycles;
	int limit;

	life_engine_top #(
		.WIDTH(WIDTH),
		.DEPTH(DEPTH)
	) life_engine_top_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.init       (init),
		.init_row   (init_row),
		.init_data  (init_data),
		.start      (start),
		.busy       (busy),
		.done       (done),
		.ld         (ld),
		.ld_row     (ld_row),
		.dout       (dout),
		.dout_valid (dout_valid)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin	// X counts as wrong
			errors++;
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// One model generation from nine-cell counts with wrap
	task automatic step_model();
		logic [WIDTH-1:0] nxt [DEPTH];
		int cnt;
		for (int r = 0; r < DEPTH; r++) begin
			for (int c = 0; c < WIDTH; c++) begin
				cnt = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						cnt += int'(model_board[(r + dr + DEPTH) % DEPTH][(c + dc + WIDTH) % WIDTH]);
					end
				end
				nxt[r][c] = (cnt == 3) || ((cnt == 4) && model_board[r][c]);	// Centre included
			end
		end
		for (int r = 0; r < DEPTH; r++) begin
			model_board[r] = nxt[r];
		end
	endtask

	// Fill the model from the table and init-write every row
	task automatic load_board(input int idx);
		for (int r = 0; r < DEPTH; r++) begin
			if (case_rand[idx]) begin
				model_board[r] = WIDTH'($urandom());
			end else begin
				model_board[r] = case_board[idx][(DEPTH - 1 - r) * WIDTH +: WIDTH];
			end
			@(posedge clk);
			#2;
			init      = 1'b1;
			init_row  = AW'(r);
			init_data = model_board[r];
		end
		@(posedge clk);
		#2 init = 1'b0;
	endtask

	// Read back all rows and check data and readout latency
	task automatic read_check(input string name, input int gen);
		int waited;
		for (int r = 0; r < DEPTH; r++) begin
			@(posedge clk);
			#2;
			ld     = 1'b1;
			ld_row = AW'(r);
			@(posedge clk);
			#2 ld = 1'b0;
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!dout_valid);
			check($sformatf("%s gen %0d row %0d latency", name, gen, r),
			      32'(RD_LATENCY), 32'(waited));
			check($sformatf("%s gen %0d row %0d", name, gen, r),
			      32'(model_board[r]), 32'(dout));
		end
	endtask

	// One pass with busy held until a single done pulse
	task automatic run_pass(input string name);
		@(posedge clk);
		#2 start = 1'b1;
		@(posedge clk);
		#2 start = 1'b0;
		@(negedge clk);
		while (!done) begin
			check({name, " busy during pass"}, 32'd1, 32'(busy));
			@(negedge clk);
		end
		check({name, " busy at done"}, 32'd0, 32'(busy));
		@(negedge clk);
		check({name, " done width"}, 32'd0, 32'(done));	// Single cycle pulse
	endtask

	// Headroom per table unit covers a pass plus a full readback
	function automatic int timeout_limit();
		int units;
		units = 0;
		for (int i = 0; i < NUM_CASES; i++) begin
			units += 4 * (case_gens[i] + 1);
		end
		return units * (DEPTH + 10) + RST_CYCLES;
	endfunction

	//////////////////////////////////////////////////////////////
	// Timeout
	//////////////////////////////////////////////////////////////

	initial begin
		cycles = 0;
		#1;
		limit = timeout_limit();
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////

	initial begin
		errors    = 0;
		checks    = 0;
		void'($urandom(SEED));
		arst_n    = 1'b0;
		init      = 1'b0;
		init_row  = '0;
		init_data = '0;
		start     = 1'b0;
		ld        = 1'b0;
		ld_row    = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#2 arst_n = 1'b1;
		@(negedge clk);
		check("reset busy", 32'd0, 32'(busy));
		check("reset done", 32'd0, 32'(done));
		check("reset dout_valid", 32'd0, 32'(dout_valid));

		// Readback after init and after every pass
		for (int i = 0; i < NUM_CASES; i++) begin
			load_board(i);
			read_check(case_name[i], 0);
			for (int g = 1; g <= case_gens[i]; g++) begin
				run_pass(case_name[i]);
				step_model();
				read_check(case_name[i], g);	// Must show the new bank
			end
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: src/life_engine_top.sv
/*
 Streaming Game of Life engine, toroidal board of DEPTH rows by WIDTH cells
 One start gives one generation, results land in the other bank
*/
`timescale 1ns/1ps
module life_engine_top #(
	parameter int WIDTH = 256,	// Cells per row
	parameter int DEPTH = 256	// Rows per board
) (
	input  logic                     clk,
	input  logic                     arst_n,
	// Init port
	input  logic                     init,
	input  logic [$clog2(DEPTH)-1:0] init_row,
	input  logic [WIDTH-1:0]         init_data,
	// Pass control
	input  logic                     start,
	output logic                     busy,
	output logic                     done,
	// Row readout
	input  logic                     ld,
	input  logic [$clog2(DEPTH)-1:0] ld_row,
	output logic [WIDTH-1:0]         dout,
	output logic                     dout_valid
);

	logic [WIDTH-1:0] rdata;	// Memory read data
	logic [WIDTH-1:0] next_row;	// Engine result row
	logic             rd_valid;

	mem_ctrl_if #(.DEPTH(DEPTH)) mem_bus ();
	row_win_if  #(.WIDTH(WIDTH)) win_bus ();

	//////////////////////////////////////////////////////////////
	// Control and memory
	//////////////////////////////////////////////////////////////

	pass_control #(
		.DEPTH(DEPTH)
	) pass_control_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.init       (init),
		.init_row   (init_row),
		.start      (start),
		.ld         (ld),
		.ld_row     (ld_row),
		.busy       (busy),
		.done       (done),
		.dout_valid (dout_valid),
		.rd_valid   (rd_valid),
		.mem        (mem_bus.ctrl)
	);

	cell_ram #(
		.WIDTH(WIDTH),
		.DEPTH(DEPTH)
	) cell_ram_inst (
		.clk        (clk),
		.init_data  (init_data),
		.engine_row (next_row),
		.mem        (mem_bus.mem),
		.rdata      (rdata)
	);

	// Readout shares the read path
	assign dout = rdata;

	//////////////////////////////////////////////////////////////
	// Life pipeline
	//////////////////////////////////////////////////////////////

	row_window #(
		.WIDTH(WIDTH)
	) row_window_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.rdata    (rdata),
		.rd_valid (rd_valid),
		.win      (win_bus.src)
	);

	life_row #(
		.WIDTH(WIDTH)
	) life_row_inst (
		.clk      (clk),
		.win      (win_bus.dst),
		.next_row (next_row)
	);

endmodule

// File: src/life_row.sv
/*
 Life rule for one full row
 Nine-cell counts with wrap at both edges, registered result
*/
`timescale 1ns/1ps
module life_row
	import life_pkg::*;
#(
	parameter int WIDTH = 256	// Row width in cells
) (
	input  logic             clk,
	row_win_if.dst           win,
	output logic [WIDTH-1:0] next_row	// New generation of the centre row
);

	// Window shift and vertical sums take the first two cycles of WR_LAG
	localparam int RES_STAGES = WR_LAG - 2;

	logic [WIDTH-1:0][1:0] add3;		// Vertical three-cell sums
	logic [WIDTH-1:0][1:0] add3_q;
	logic [WIDTH-1:0]      centre_q;	// Current state of each cell
	logic [WIDTH-1:0][3:0] add9;		// Nine-cell count, includes centre
	logic [WIDTH-1:0]      alive;
	logic [WIDTH-1:0]      res_q [RES_STAGES];

	//////////////////////////////////////////////////////////////
	// Vertical sums, registered
	//////////////////////////////////////////////////////////////

	always_comb begin
		for (int ii = 0; ii < WIDTH; ii++) begin
			add3[ii] = {1'b0, win.above[ii]} + {1'b0, win.centre[ii]} + {1'b0, win.below[ii]};
		end
	end

	always_ff @(posedge clk) begin
		if (win.win_valid) begin
			add3_q   <= add3;
			centre_q <= win.centre;
		end
	end

	//////////////////////////////////////////////////////////////
	// Horizontal sums and rule
	//////////////////////////////////////////////////////////////

	always_comb begin
		for (int ii = 0; ii < WIDTH; ii++) begin
			add9[ii] = {2'b00, add3_q[(ii == 0) ? WIDTH - 1 : ii - 1]} +	// Left wrap
			           {2'b00, add3_q[ii]} +
			           {2'b00, add3_q[(ii == WIDTH - 1) ? 0 : ii + 1]};	// Right wrap
			// Count 3 births or survives, count 4 only survives
			alive[ii] = (add9[ii] == 4'd3) || ((add9[ii] == 4'd4) && centre_q[ii]);
		end
	end

	// Result register
	always_ff @(posedge clk) begin
		res_q[0] <= alive;
		for (int i = 1; i < RES_STAGES; i++) begin
			res_q[i] <= res_q[i-1];
		end
	end

	assign next_row = res_q[RES_STAGES-1];	// Engine write data

endmodule

// File: src/row_window.sv
/*
 Three-row shift window
 Shifts in each memory read word as it arrives during a pass
*/
`timescale 1ns/1ps
module row_window #(
	parameter int WIDTH = 256	// Row width in cells
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic [WIDTH-1:0] rdata,		// Memory read data
	input  logic             rd_valid,	// rdata holds a pass read
	row_win_if.src           win
);

	logic [WIDTH-1:0] above_q;
	logic [WIDTH-1:0] centre_q;
	logic [WIDTH-1:0] below_q;
	logic [1:0]       fill;		// Rows shifted in, saturates at 3

	// Row data, advances only on valid reads
	always_ff @(posedge clk) begin
		if (rd_valid) begin
			above_q  <= centre_q;
			centre_q <= below_q;
			below_q  <= rdata;	// Newest row at the bottom
		end
	end

	// Fill count
	// Clears once the run of reads ends, so the next pass refills
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fill <= '0;
		end else if (!rd_valid) begin
			fill <= '0;
		end else if (fill != 2'd3) begin
			fill <= fill + 2'd1;
		end
	end

	assign win.above     = above_q;
	assign win.centre    = centre_q;
	assign win.below     = below_q;
	assign win.win_valid = (fill == 2'd3);	// Three rows present

endmodule

// File: src/pass_control.sv
/*
 Pass controller for the Life engine
 Sequences init writes, row readout and one generation pass per start
*/
`timescale 1ns/1ps
module pass_control
	import life_pkg::*;
#(
	parameter int DEPTH = 256	// Rows per bank
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     init,		// Init write strobe
	input  logic [$clog2(DEPTH)-1:0] init_row,
	input  logic                     start,		// Pass request
	input  logic                     ld,		// Readout strobe
	input  logic [$clog2(DEPTH)-1:0] ld_row,
	output logic                     busy,
	output logic                     done,		// One cycle at pass end
	output logic                     dout_valid,
	output logic                     rd_valid,	// Read data valid for the window
	mem_ctrl_if.ctrl                 mem
);

	localparam int AW   = $clog2(DEPTH);		// Row address bits
	localparam int CW   = $clog2(DEPTH + 2);	// Read counter bits
	localparam int LINE = RD_LATENCY + WR_LAG;	// Write delay line depth

	ctrl_state_e state;

	logic                  bank;		// Active bank holding the current generation
	logic [AW-1:0]         rd_row;		// Row being read with wrap
	logic [CW-1:0]         rd_cnt;		// Reads issued this pass
	logic [AW-1:0]         ctr_row;		// Centre row of the window this read completes
	logic                  issue;
	logic                  init_go;
	logic                  ld_go;
	logic                  last_wr;
	logic [LINE-1:0]       vld_q;		// Every read in flight
	logic [LINE-1:0]       wr_q;		// Reads that complete a window
	logic [AW-1:0]         row_q [LINE];	// Write row travelling with wr_q
	logic [RD_LATENCY-1:0] ld_q;		// Readout strobe delay

	assign busy    = (state != ST_IDLE);
	assign init_go = init & ~busy;	// Ignored during a pass
	assign ld_go   = ld & ~busy;
	assign issue   = (state == ST_READ);	// One read per cycle
	assign ctr_row = (rd_row == '0) ? AW'(DEPTH - 1) : rd_row - 1'b1;

	// Last read has reached the write end with nothing behind it
	assign last_wr = (state == ST_DRAIN) & vld_q[LINE-1] & ~(|vld_q[LINE-2:0]);

	//////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= ST_IDLE;
			bank   <= 1'b0;
			rd_row <= '0;
			rd_cnt <= '0;
			done   <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state  <= ST_READ;
						rd_row <= AW'(DEPTH - 1);	// Start one row above 0
						rd_cnt <= '0;
					end
				end
				ST_READ: begin
					rd_row <= (rd_row == AW'(DEPTH - 1)) ? '0 : rd_row + 1'b1;
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_cnt == CW'(DEPTH + 1)) begin	// DEPTH+2 reads out
						state <= ST_DRAIN;
					end
				end
				ST_DRAIN: begin
					if (last_wr) begin
						state <= ST_IDLE;
						bank  <= ~bank;	// New generation becomes active
						done  <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////
	// Delay lines
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
			wr_q  <= '0;
			ld_q  <= '0;
		end else begin
			vld_q <= {vld_q[LINE-2:0], issue};
			wr_q  <= {wr_q[LINE-2:0], issue & (rd_cnt >= CW'(2))};	// First two only fill
			ld_q  <= {ld_q[RD_LATENCY-2:0], ld_go};
		end
	end

	// Write row numbers ride along with the valid bits
	always_ff @(posedge clk) begin
		row_q[0] <= ctr_row;
		for (int i = 1; i < LINE; i++) begin
			row_q[i] <= row_q[i-1];
		end
	end

	assign rd_valid   = vld_q[RD_LATENCY-1];	// Lines up with rdata
	assign dout_valid = ld_q[RD_LATENCY-1];

	// Memory control
	always_comb begin
		mem.raddr = {bank, ld_row};	// Readout when idle
		if (state == ST_READ) begin
			mem.raddr = {bank, rd_row};
		end
		mem.init_sel = init_go;
		mem.we       = init_go | wr_q[LINE-1];
		mem.waddr    = init_go ? {bank, init_row} : {~bank, row_q[LINE-1]};	// Results to other bank
	end

endmodule

// File: src/cell_ram.sv
/*
 Two-bank row memory for the Life board
 Registered read address and output, init or engine write data
*/
`timescale 1ns/1ps
module cell_ram
	import life_pkg::*;
#(
	parameter int WIDTH = 256,	// Row width in cells
	parameter int DEPTH = 256	// Rows per bank
) (
	input  logic             clk,
	input  logic [WIDTH-1:0] init_data,	// Row from the init port
	input  logic [WIDTH-1:0] engine_row,	// Row from the life pipeline
	mem_ctrl_if.mem          mem,
	output logic [WIDTH-1:0] rdata		// Feeds dout and the window
);

	localparam int AW = $clog2(DEPTH);

	// Bank 0 in the lower half, bank 1 in the upper half
	logic [WIDTH-1:0] ram [2*DEPTH];

	logic [AW:0]      raddr_q;	// Registered read address
	logic [WIDTH-1:0] wdata;
	logic [WIDTH-1:0] rd_pipe [RD_LATENCY-1];	// Output register stages

	// Write data select
	assign wdata = mem.init_sel ? init_data : engine_row;

	//////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (mem.we) begin
			ram[mem.waddr] <= wdata;	// Writes hit the bank not being read
		end
	end

	//////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		raddr_q    <= mem.raddr;
		rd_pipe[0] <= ram[raddr_q];
		for (int i = 1; i < RD_LATENCY - 1; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];	// Extra stages if latency grows
		end
	end

	// Last output stage
	assign rdata = rd_pipe[RD_LATENCY-2];

endmodule

// File: src/life_if.sv
/*
 Life engine internal buses
 Memory control from the controller, and the three-row window
*/
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////
// Memory control
//////////////////////////////////////////////////////////////

interface mem_ctrl_if #(
	parameter int DEPTH = 256	// Rows per bank
) ();

	localparam int AW = $clog2(DEPTH);	// Row address bits

	// Addresses carry the bank bit on top
	logic [AW:0] raddr;	// Read address, bank + row
	logic [AW:0] waddr;	// Write address, bank + row
	logic        we;		// Write enable
	logic        init_sel;	// Write data from init port

	// Controller side
	modport ctrl (
		output raddr,
		output waddr,
		output we,
		output init_sel
	);

	// Memory side
	modport mem (
		input raddr,
		input waddr,
		input we,
		input init_sel
	);

endinterface

//////////////////////////////////////////////////////////////
// Three-row window
//////////////////////////////////////////////////////////////

interface row_win_if #(
	parameter int WIDTH = 256	// Cells per row
) ();

	logic [WIDTH-1:0] above;	// Row r-1
	logic [WIDTH-1:0] centre;	// Row r, the one being updated
	logic [WIDTH-1:0] below;	// Row r+1
	logic             win_valid;	// All three rows present

	modport src (output above, centre, below, win_valid);
	modport dst (input above, centre, below, win_valid);

endinterface

// File: src/life_pkg.sv
/*
 Life engine shared definitions
 Controller state type and pipeline latency constants
*/
package life_pkg;

	//////////////////////////////////////////////////////////////
	// Controller states
	//////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,	// Init and readout allowed
		ST_READ  = 2'd1,	// Streaming DEPTH+2 reads
		ST_DRAIN = 2'd2		// Waiting for the last rows in flight
	} ctrl_state_e;

	//////////////////////////////////////////////////////////////
	// Pipeline latencies
	//////////////////////////////////////////////////////////////

	// Read address to read data
	// One cycle in the address register and one in the output register
	localparam int RD_LATENCY = 2;

	// Read data arrival to write of the finished row
	//   1 window shift
	//   1 vertical sums
	//   1 life rule result
	localparam int WR_LAG = 3;

	// The controller write delay line is RD_LATENCY+WR_LAG deep
	// from the cycle the read address goes out.
	// Several rows are in flight at once, one per cycle.

	// Full pass runs DEPTH+2 reads plus the pipeline tail
	// and the bank swaps on the last write edge

endpackage
